// ==== Makefile ====
TOP := tb_sd_spi_tx
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f filelist.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== filelist.f ====
hw/sd_spi_pkg.sv
hw/sd_crc7_gen.sv
hw/sd_crc16_gen.sv
hw/sd_frame_ctrl.sv
hw/sd_spi_tx.sv
tb/tb_sd_spi_tx.sv

// ==== hw/sd_crc16_gen.sv ====
// CRC16 generator: folds block bits into the remainder, then shifts it out
`timescale 1ns/1ps
`default_nettype none

module sd_crc16_gen
  import sd_spi_pkg::*;
(
  input  logic        clock,
  input  logic        rst,
  input  sd_crc_ctl_t crc_ctl,
  output logic        crc16_msb
);

  logic [CRC16_BITS-1:0] crc_q;
  logic                  fb;

  // CCITT feedback, x^16 + x^12 + x^5 + 1
  assign fb = crc_q[CRC16_BITS-1] ^ crc_ctl.bit_in;

  always_ff @(posedge clock) begin
    if (rst) begin
      crc_q <= '0;
    end else if (crc_ctl.clear) begin
      crc_q <= '0;
    end else if (crc_ctl.feed) begin
      crc_q <= {crc_q[14:12],
                crc_q[11] ^ fb,
                crc_q[10:5],
                crc_q[4] ^ fb,
                crc_q[3:0],
                fb};
    end else if (crc_ctl.shift) begin
      crc_q <= {crc_q[CRC16_BITS-2:0], 1'b1};
    end
  end

  assign crc16_msb = crc_q[CRC16_BITS-1];

  // Feed and shift windows never overlap
  a_feed_shift: assert property (
    @(posedge clock) disable iff (rst)
    !(crc_ctl.feed && crc_ctl.shift)
  ) else $error("crc16: feed and shift high together");

  // Shift window always directly follows the last fed bit
  a_shift_after_feed: assert property (
    @(posedge clock) disable iff (rst)
    (crc_ctl.shift && !$past(crc_ctl.shift)) |-> $past(crc_ctl.feed)
  ) else $error("crc16: shift window not preceded by feed");

endmodule

`default_nettype wire

// ==== hw/sd_crc7_gen.sv ====
// CRC7 generator: folds command bits into the remainder, then shifts it out
`timescale 1ns/1ps
`default_nettype none

module sd_crc7_gen
  import sd_spi_pkg::*;
(
  input  logic        clock,
  input  logic        rst,
  input  sd_crc_ctl_t crc_ctl,
  output logic        crc7_msb
);

  logic [CRC7_BITS-1:0] crc_q;
  logic                 fb;

  // Feedback for x^7 + x^3 + 1
  assign fb = crc_q[CRC7_BITS-1] ^ crc_ctl.bit_in;

  always_ff @(posedge clock) begin
    if (rst) begin
      crc_q <= '0;
    end else if (crc_ctl.clear) begin
      crc_q <= '0;
    end else if (crc_ctl.feed) begin
      crc_q <= {crc_q[5:3], crc_q[2] ^ fb, crc_q[1:0], fb};
    end else if (crc_ctl.shift) begin
      // Ones fill in behind as the remainder goes out
      crc_q <= {crc_q[CRC7_BITS-2:0], 1'b1};
    end
  end

  assign crc7_msb = crc_q[CRC7_BITS-1];

  // Controller phases are exclusive
  a_ctl_exclusive: assert property (
    @(posedge clock) disable iff (rst)
    $onehot0({crc_ctl.clear, crc_ctl.feed, crc_ctl.shift})
  ) else $error("crc7: clear, feed and shift overlap");

endmodule

`default_nettype wire

// ==== hw/sd_frame_ctrl.sv ====
// Frame controller: request latch, payload shift register, bit counter and mosi mux
`timescale 1ns/1ps
`default_nettype none

module sd_frame_ctrl
  import sd_spi_pkg::*;
(
  input  logic        clock,
  input  logic        rst,
  input  sd_request_t req,
  input  logic        req_valid,
  input  logic        crc7_msb,
  input  logic        crc16_msb,
  output sd_crc_ctl_t crc_ctl,
  output logic        mosi,
  output logic        sending
);

  logic                   accept;
  logic                   is_data_q;
  logic [FRAME_SR_W-1:0]  frame_sr_q;
  logic [FRAME_SR_W-1:0]  frame_load;
  logic [BIT_COUNT_W-1:0] count_q;
  logic [BIT_COUNT_W-1:0] count_load;

  // Remaining-bit thresholds for the current frame kind
  logic [BIT_COUNT_W-1:0] crc_from;
  logic                   payload_phase;
  logic                   crc_phase;
  logic                   token_phase;
  logic                   sr_msb;

  // Strobes while busy are simply dropped
  assign accept = req_valid && !sending;

  always_comb begin
    if (req.is_data) begin
      frame_load = {START_TOKEN, req.block};
      count_load = BIT_COUNT_W'(DATA_FRAME_BITS);
    end else begin
      // Start bit, transmission bit, index, argument, then idle ones
      frame_load = {1'b0, 1'b1, req.cmd_index, req.argument,
                    {(FRAME_SR_W - CMD_CRC_START){1'b1}}};
      count_load = BIT_COUNT_W'(CMD_FRAME_BITS);
    end
  end

  // Latched kind and payload
  always_ff @(posedge clock) begin
    if (accept) begin
      is_data_q  <= req.is_data;
      frame_sr_q <= frame_load;
    end else if (sending) begin
      frame_sr_q <= {frame_sr_q[FRAME_SR_W-2:0], 1'b1};
    end
  end

  // Count of bits still to send, and the busy flag
  always_ff @(posedge clock) begin
    if (rst) begin
      count_q <= '0;
      sending <= 1'b0;
    end else if (accept) begin
      count_q <= count_load;
      sending <= 1'b1;
    end else if (sending) begin
      count_q <= count_q - 1'b1;
      if (count_q == BIT_COUNT_W'(1)) begin
        sending <= 1'b0;
      end
    end
  end

  assign crc_from = is_data_q ? BIT_COUNT_W'(CRC16_BITS)
                              : BIT_COUNT_W'(CMD_FRAME_BITS - CMD_CRC_START);

  assign sr_msb = frame_sr_q[FRAME_SR_W-1];

  always_comb begin
    payload_phase = sending && (count_q > crc_from);
    // Command CRC stops one short of the end bit
    crc_phase     = sending && (count_q <= crc_from)
                    && (is_data_q || (count_q > BIT_COUNT_W'(1)));
    // Token bits go out but are not part of the CRC16
    token_phase   = is_data_q && (count_q > BIT_COUNT_W'(BLOCK_BITS + CRC16_BITS));
  end

  always_comb begin
    if (payload_phase) begin
      mosi = sr_msb;
    end else if (crc_phase) begin
      mosi = is_data_q ? crc16_msb : crc7_msb;
    end else begin
      // End bit and idle
      mosi = 1'b1;
    end
  end

  always_comb begin
    crc_ctl.clear  = accept;
    crc_ctl.feed   = payload_phase && !token_phase;
    crc_ctl.shift  = crc_phase;
    crc_ctl.bit_in = sr_msb;
  end

  // Busy flag and counter are kept in separate flops
  a_sending_count: assert property (
    @(posedge clock) disable iff (rst)
    sending == (count_q != '0)
  ) else $error("frame_ctrl: sending disagrees with bit counter");

  a_idle_high: assert property (
    @(posedge clock) disable iff (rst)
    !sending |-> mosi
  ) else $error("frame_ctrl: mosi low while idle");

endmodule

`default_nettype wire

// ==== hw/sd_spi_pkg.sv ====
// Frame sizes, start token, request and CRC control types for the SD SPI transmitter
`default_nettype none

package sd_spi_pkg;

  // Bit counter
  localparam int BIT_COUNT_W = 10;

  // Command frame layout
  localparam int CMD_FRAME_BITS = 48;
  localparam int CMD_CRC_START  = 40;
  localparam int CRC7_BITS      = 7;

  // Data frame layout, block cut down to 64 bytes
  localparam int BLOCK_BITS      = 512;
  localparam int TOKEN_BITS      = 8;
  localparam int CRC16_BITS      = 16;
  localparam int DATA_FRAME_BITS = TOKEN_BITS + BLOCK_BITS + CRC16_BITS;

  // Shift register holds the token plus block, the longest payload
  localparam int FRAME_SR_W = TOKEN_BITS + BLOCK_BITS;

  localparam logic [TOKEN_BITS-1:0] START_TOKEN = 8'hFE;

  // One request from the controller
  typedef struct packed {
    logic                  is_data;
    logic [5:0]            cmd_index;
    logic [31:0]           argument;
    logic [BLOCK_BITS-1:0] block;
  } sd_request_t;

  // Shared control for both CRC units
  typedef struct packed {
    logic clear;
    logic feed;
    logic shift;
    logic bit_in;
  } sd_crc_ctl_t;

endpackage

`default_nettype wire

// ==== hw/sd_spi_tx.sv ====
// SD SPI transmit path top: frame controller with CRC7 and CRC16 units
`timescale 1ns/1ps
`default_nettype none

module sd_spi_tx
  import sd_spi_pkg::*;
(
  input  logic        clock,
  input  logic        rst,
  input  sd_request_t req,
  input  logic        req_valid,
  output logic        mosi,
  output logic        sending
);

  sd_crc_ctl_t crc_ctl;
  logic        crc7_msb;
  logic        crc16_msb;

  sd_frame_ctrl i_sd_frame_ctrl (
    .clock     (clock),
    .rst       (rst),
    .req       (req),
    .req_valid (req_valid),
    .crc7_msb  (crc7_msb),
    .crc16_msb (crc16_msb),
    .crc_ctl   (crc_ctl),
    .mosi      (mosi),
    .sending   (sending)
  );

  // Both CRC units see the same bit stream
  sd_crc7_gen i_sd_crc7_gen (
    .clock    (clock),
    .rst      (rst),
    .crc_ctl  (crc_ctl),
    .crc7_msb (crc7_msb)
  );

  sd_crc16_gen i_sd_crc16_gen (
    .clock     (clock),
    .rst       (rst),
    .crc_ctl   (crc_ctl),
    .crc16_msb (crc16_msb)
  );

endmodule

`default_nettype wire

// ==== tb/sd_frame_vectors.txt ====
# kind (0 command, 1 data), index (decimal), argument, block, expected CRC, gap (decimal)
# Hex fields; block leading zeros dropped, CRC is CRC7 for commands and CRC16 for data
0  0 00000000 0                  4a   2
0  8 000001aa 0                  43   0
0 55 00000000 0                  32   1
0 41 40000000 0                  3b   0
1  0 00000000 0                  0000 3
1  0 00000000 1                  1021 0
1  0 00000000 f                  f1ef 1
1  0 00000000 313233343536373839 31c3 0
0 41 40000000 0                  3b   1
1  0 00000000 1                  1021 0
0  0 00000000 0                  4a   2

// ==== tb/tb_sd_spi_tx.sv ====
// Testbench for the SD SPI transmitter: vector file, random blocks, busy strobes and reset
`timescale 1ns/1ps
`default_nettype none

module tb_sd_spi_tx
  import sd_spi_pkg::*;
();

  logic        clock;
  logic        rst;
  sd_request_t req;
  logic        req_valid;
  logic        mosi;
  logic        sending;

  // Requests from the file, then the random blocks
  sd_request_t vec_req[$];
  logic [15:0] vec_crc[$];
  int          vec_gap[$];

  int          mismatch_count = 0;
  int          failure_count  = 0;
  int          cycle_count    = 0;
  int          cycle_limit    = 1000000;
  logic [31:0] rng_state      = 32'd9;

  sd_spi_tx i_sd_spi_tx (
    .clock     (clock),
    .rst       (rst),
    .req       (req),
    .req_valid (req_valid),
    .mosi      (mosi),
    .sending   (sending)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // Cycle watchdog
  initial begin
    while (cycle_count < cycle_limit) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the run did not finish", cycle_count);
    $display("=== FAIL ===");
    $finish;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Bitwise CCITT CRC16, zero start value, block MSB first
  function automatic logic [15:0] crc16_ref(input logic [BLOCK_BITS-1:0] block);
    logic [15:0] crc;
    logic        fb;
    crc = '0;
    for (int i = BLOCK_BITS - 1; i >= 0; i--) begin
      fb  = crc[15] ^ block[i];
      crc = {crc[14:0], 1'b0};
      if (fb) begin
        crc = crc ^ 16'h1021;
      end
    end
    return crc;
  endfunction

  function automatic int frame_length(input sd_request_t r);
    return r.is_data ? DATA_FRAME_BITS : CMD_FRAME_BITS;
  endfunction

  // Right aligned, first bit on the wire is the MSB of the frame length
  function automatic logic [DATA_FRAME_BITS-1:0] expected_frame(input sd_request_t r,
                                                               input logic [15:0] crc);
    if (r.is_data) begin
      return {8'hFE, r.block, crc};
    end
    return {{(DATA_FRAME_BITS - CMD_FRAME_BITS){1'b0}},
            1'b0, 1'b1, r.cmd_index, r.argument, crc[6:0], 1'b1};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      mismatch_count++;
      $display("MISMATCH at %0t: %s got %0h expected %0h", $time, name, got, expected);
    end
  endtask

  task automatic report_failure(input string msg);
    failure_count++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic load_vectors();
    int                    fd;
    int                    n;
    int                    kind;
    int                    index;
    int                    gap;
    string                 line;
    logic [31:0]           arg;
    logic [BLOCK_BITS-1:0] blk;
    logic [15:0]           crc;
    sd_request_t           r;
    fd = $fopen("tb/sd_frame_vectors.txt", "r");
    if (fd == 0) begin
      report_failure("could not open tb/sd_frame_vectors.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Comment and blank lines do not scan
      n = $sscanf(line, "%d %d %h %h %h %d", kind, index, arg, blk, crc, gap);
      if (n == 6) begin
        r           = '0;
        r.is_data   = (kind != 0);
        r.cmd_index = 6'(index);
        r.argument  = arg;
        r.block     = blk;
        vec_req.push_back(r);
        vec_crc.push_back(crc);
        vec_gap.push_back(gap);
      end
    end
    $fclose(fd);
  endtask

  task automatic idle_wait(input int cycles);
    repeat (cycles) begin
      @(negedge clock);
      check_value("sending", 32'(sending), 32'd0);
      check_value("mosi", 32'(mosi), 32'd1);
    end
  endtask

  // Strobe one request and follow its frame bit by bit
  task automatic run_frame(input sd_request_t r, input logic [15:0] crc, input int busy_at);
    logic [DATA_FRAME_BITS-1:0] frame;
    logic [7:0]                 last_byte;
    logic                       short_frame;
    sd_request_t                other;
    int                         len;
    frame           = expected_frame(r, crc);
    len             = frame_length(r);
    last_byte       = '0;
    short_frame     = 1'b0;
    other           = r;
    other.is_data   = ~r.is_data;
    other.cmd_index = r.cmd_index + 6'd1;
    other.block     = ~r.block;
    req             = r;
    req_valid       = 1'b1;
    @(negedge clock);
    req_valid = 1'b0;
    for (int k = 0; k < len; k++) begin
      if (!sending) begin
        if (k == 0) begin
          report_failure("sending did not rise in the cycle after the strobe");
        end else begin
          report_failure($sformatf("frame ended after %0d of %0d bits", k, len));
        end
        short_frame = 1'b1;
        break;
      end
      check_value($sformatf("mosi[%0d]", k), 32'(mosi), 32'(frame[len-1-k]));
      last_byte = {last_byte[6:0], mosi};
      // Second request while busy, must be lost
      req_valid = (k == busy_at);
      if (k == busy_at) begin
        req = other;
      end
      @(negedge clock);
    end
    req_valid = 1'b0;
    if (!short_frame) begin
      if (sending) begin
        report_failure($sformatf("sending still high after %0d bits", len));
        while (sending) begin
          @(negedge clock);
        end
      end
      check_value("mosi", 32'(mosi), 32'd1);
      if (!r.is_data && r.cmd_index == 6'd0 && r.argument == 32'd0) begin
        check_value("cmd0 last byte", 32'(last_byte), 32'h95);
      end
    end
  endtask

  task automatic reset_mid_frame(input sd_request_t r, input int bits_sent);
    req       = r;
    req_valid = 1'b1;
    @(negedge clock);
    req_valid = 1'b0;
    repeat (bits_sent) @(negedge clock);
    if (!sending) begin
      report_failure("sending was already low before the mid-frame reset");
    end
    rst = 1'b1;
    @(negedge clock);
    rst = 1'b0;
    check_value("sending", 32'(sending), 32'd0);
    check_value("mosi", 32'(mosi), 32'd1);
  endtask

  initial begin
    sd_request_t r;
    int          budget;
    int          ra;
    int          rb;
    rst       = 1'b1;
    req       = '0;
    req_valid = 1'b0;
    load_vectors();

    // Two random data blocks, the second one back to back with the first
    for (int n = 0; n < 2; n++) begin
      r         = '0;
      r.is_data = 1'b1;
      for (int w = 0; w < BLOCK_BITS / 32; w++) begin
        rng_state            = lcg_next(rng_state);
        r.block[w*32 +: 32]  = rng_state;
      end
      vec_req.push_back(r);
      vec_crc.push_back(crc16_ref(r.block));
      vec_gap.push_back((n == 0) ? 0 : 2);
    end
    ra = vec_req.size() - 2;
    rb = vec_req.size() - 1;

    budget = 16 + 200;
    foreach (vec_req[j]) begin
      budget += frame_length(vec_req[j]) + vec_gap[j] + 2;
    end
    // Busy strobe runs, then the reset run and its two follow-up frames
    budget += CMD_FRAME_BITS + DATA_FRAME_BITS + 24;
    budget += 300 + CMD_FRAME_BITS + DATA_FRAME_BITS + 16;
    cycle_limit = budget;

    repeat (16) @(negedge clock);
    rst = 1'b0;
    check_value("sending", 32'(sending), 32'd0);
    check_value("mosi", 32'(mosi), 32'd1);

    for (int i = 0; i < vec_req.size(); i++) begin
      run_frame(vec_req[i], vec_crc[i], -1);
      idle_wait(vec_gap[i]);
    end

    if (vec_req.size() >= 4) begin
      // Strobe mid-frame, then one on the very last bit
      run_frame(vec_req[0], vec_crc[0], 20);
      idle_wait(10);
      run_frame(vec_req[ra], vec_crc[ra], DATA_FRAME_BITS - 1);
      idle_wait(10);
      reset_mid_frame(vec_req[rb], 300);
      idle_wait(2);
      run_frame(vec_req[1], vec_crc[1], -1);
      idle_wait(2);
      run_frame(vec_req[rb], vec_crc[rb], -1);
      idle_wait(2);
    end else begin
      report_failure("fewer than four requests available, scenarios skipped");
    end

    $display("Finished: %0d mismatches, %0d other errors", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
